//--- Makefile
# decode and rename stage, Verilator simulation

sim:
	verilator --binary --timing -Wno-fatal --top-module decode_stage_tb \
		-f rename_decode.f -o sim_decode_stage
	./obj_dir/sim_decode_stage | tee run.log
	grep -q "TEST OK" run.log

clean:
	rm -rf obj_dir run.log

.PHONY: sim clean

//--- rename_decode.f
source/decode_pkg.sv
source/issue_buffer.sv
source/control_unit.sv
source/imm_generator.sv
source/register_alias_table.sv
source/tag_allocator.sv
source/issue_register.sv
source/decode_stage.sv
+incdir+testbench
testbench/decode_stage_tb.sv

//--- source/control_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opcode and funct decode into control fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module control_unit (
	input  decode_pkg::inst_word_t cur_inst,
	output logic [3:0] alu_op,
	output logic alu_src_imm,
	output logic [1:0] mem_op,
	output logic is_branch,
	output logic reg_write
);

	logic writes;

	// alt selects sub/sra, only honoured for sub on register ops
	function automatic logic [3:0] alu_from_funct(input logic [2:0] f3, input logic alt,
			input logic is_reg);
		case (f3)
			decode_pkg::f3_add_sub: return (alt && is_reg) ? decode_pkg::alu_sub
				: decode_pkg::alu_add;
			decode_pkg::f3_sll: return decode_pkg::alu_sll;
			decode_pkg::f3_slt, decode_pkg::f3_sltu: return decode_pkg::alu_slt;
			decode_pkg::f3_xor: return decode_pkg::alu_xor;
			decode_pkg::f3_srl_sra: return alt ? decode_pkg::alu_sra : decode_pkg::alu_srl;
			decode_pkg::f3_or: return decode_pkg::alu_or;
			default: return decode_pkg::alu_and;
		endcase
	endfunction

	always_comb begin
		alu_op = decode_pkg::alu_add;
		alu_src_imm = 1'b0;
		mem_op = decode_pkg::mem_none;
		is_branch = 1'b0;
		writes = 1'b0;
		case (cur_inst.r_view.opcode)
			decode_pkg::op_r: begin
				alu_op = alu_from_funct(cur_inst.r_view.funct3, cur_inst.r_view.funct7[5], 1'b1);
				writes = 1'b1;
			end
			decode_pkg::op_i: begin
				alu_op = alu_from_funct(cur_inst.r_view.funct3, cur_inst.r_view.funct7[5], 1'b0);
				alu_src_imm = 1'b1;
				writes = 1'b1;
			end
			decode_pkg::op_load: begin
				alu_src_imm = 1'b1;
				mem_op = decode_pkg::mem_load;
				writes = 1'b1;
			end
			decode_pkg::op_store: begin
				alu_src_imm = 1'b1;
				mem_op = decode_pkg::mem_store;
			end
			// compare both sources
			decode_pkg::op_branch: begin
				alu_op = decode_pkg::alu_sub;
				is_branch = 1'b1;
			end
			decode_pkg::op_lui: begin
				alu_src_imm = 1'b1;
				writes = 1'b1;
			end
			// jump with link
			decode_pkg::op_jal: begin
				alu_src_imm = 1'b1;
				is_branch = 1'b1;
				writes = 1'b1;
			end
			default: begin
				writes = 1'b0;
			end
		endcase
	end

	// writes to x0 are dropped
	assign reg_write = writes & (cur_inst.r_view.rd != '0);

endmodule

//--- source/decode_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I opcode, funct3, ALU and memory op constants
// and the instruction word union with its two views
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package decode_pkg;

	localparam int arch_reg_width = 5;
	localparam int inst_width = 32;

	// base opcodes, all zero is the no-op
	localparam logic [6:0] op_r      = 7'b0110011;
	localparam logic [6:0] op_i      = 7'b0010011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_nop    = 7'b0000000;

	// funct3 of the arithmetic group
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_srl_sra = 3'b101;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	localparam logic [3:0] alu_add = 4'd0;
	localparam logic [3:0] alu_sub = 4'd1;
	localparam logic [3:0] alu_and = 4'd2;
	localparam logic [3:0] alu_or  = 4'd3;
	localparam logic [3:0] alu_xor = 4'd4;
	localparam logic [3:0] alu_sll = 4'd5;
	localparam logic [3:0] alu_srl = 4'd6;
	localparam logic [3:0] alu_sra = 4'd7;
	localparam logic [3:0] alu_slt = 4'd8;

	localparam logic [1:0] mem_none  = 2'd0;
	localparam logic [1:0] mem_load  = 2'd1;
	localparam logic [1:0] mem_store = 2'd2;

	// register layout and store layout of the same word
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [arch_reg_width-1:0] rs2;
			logic [arch_reg_width-1:0] rs1;
			logic [2:0] funct3;
			logic [arch_reg_width-1:0] rd;
			logic [6:0] opcode;
		} r_view;
		struct packed {
			logic [6:0] imm_hi;
			logic [arch_reg_width-1:0] rs2;
			logic [arch_reg_width-1:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s_view;
	} inst_word_t;

endpackage

//--- source/decode_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode and rename stage top level
// input buffer, decode, rename, tags, output register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_stage #(
	parameter int phys_reg_count = 64,
	parameter int rob_size = 16,
	parameter int commit_width = 2,
	parameter int addr_width = 32,
	localparam int phys_reg_width = $clog2(phys_reg_count),
	localparam int tag_width = $clog2(rob_size)
) (
	input  logic clk,
	input  logic reset,
	input  logic inst_valid,
	input  decode_pkg::inst_word_t inst,
	input  logic [addr_width-1:0] pc,
	input  logic stall,
	input  logic flush,
	input  logic [commit_width-1:0] commit_valid,
	input  logic [commit_width-1:0] commit_writes,
	input  logic [commit_width-1:0][phys_reg_width-1:0] commit_phys,
	output logic inst_ready,
	output logic out_valid,
	output logic [addr_width-1:0] out_pc,
	output logic [tag_width-1:0] out_tag,
	output logic rob_full,
	output logic [3:0] alu_op,
	output logic alu_src_imm,
	output logic [1:0] mem_op,
	output logic is_branch,
	output logic reg_write,
	output logic [phys_reg_width-1:0] phys_rs1,
	output logic [phys_reg_width-1:0] phys_rs2,
	output logic [phys_reg_width-1:0] phys_rd,
	output logic [decode_pkg::arch_reg_width-1:0] arch_rd,
	output logic [decode_pkg::inst_width-1:0] immediate
);

	logic cur_valid;
	decode_pkg::inst_word_t cur_inst;
	logic [addr_width-1:0] cur_pc;
	logic accept;
	logic can_rename;
	logic [tag_width-1:0] next_tag;

	// decoded, not yet registered
	logic [3:0] dec_alu_op;
	logic dec_alu_src_imm;
	logic [1:0] dec_mem_op;
	logic dec_is_branch;
	logic dec_reg_write;
	logic [decode_pkg::inst_width-1:0] dec_immediate;
	logic [phys_reg_width-1:0] ren_rs1;
	logic [phys_reg_width-1:0] ren_rs2;
	logic [phys_reg_width-1:0] ren_rd;

	issue_buffer #(.addr_width(addr_width)) buffer0 (
		.clk(clk), .reset(reset), .inst_valid(inst_valid), .inst(inst), .pc(pc),
		.stall(stall), .flush(flush), .can_rename(can_rename), .rob_full(rob_full),
		.writes_rd(dec_reg_write), .inst_ready(inst_ready), .cur_valid(cur_valid),
		.cur_inst(cur_inst), .cur_pc(cur_pc), .accept(accept)
	);

	control_unit control0 (
		.cur_inst(cur_inst), .alu_op(dec_alu_op), .alu_src_imm(dec_alu_src_imm),
		.mem_op(dec_mem_op), .is_branch(dec_is_branch), .reg_write(dec_reg_write)
	);

	imm_generator imm0 (.cur_inst(cur_inst), .immediate(dec_immediate));

	register_alias_table #(
		.phys_reg_count(phys_reg_count), .phys_reg_width(phys_reg_width),
		.commit_width(commit_width)
	) rat0 (
		.clk(clk), .reset(reset), .cur_inst(cur_inst), .reg_write(dec_reg_write),
		.accept(accept), .commit_valid(commit_valid), .commit_writes(commit_writes),
		.commit_phys(commit_phys), .phys_rs1(ren_rs1), .phys_rs2(ren_rs2),
		.phys_rd(ren_rd), .can_rename(can_rename)
	);

	tag_allocator #(
		.rob_size(rob_size), .tag_width(tag_width), .commit_width(commit_width)
	) tags0 (
		.clk(clk), .reset(reset), .accept(accept), .commit_valid(commit_valid),
		.next_tag(next_tag), .rob_full(rob_full)
	);

	issue_register #(
		.addr_width(addr_width), .phys_reg_width(phys_reg_width), .tag_width(tag_width)
	) out0 (
		.clk(clk), .reset(reset), .accept(accept), .flush(flush), .cur_valid(cur_valid),
		.cur_pc(cur_pc), .next_tag(next_tag), .dec_alu_op(dec_alu_op),
		.dec_alu_src_imm(dec_alu_src_imm), .dec_mem_op(dec_mem_op),
		.dec_is_branch(dec_is_branch), .dec_reg_write(dec_reg_write),
		.dec_immediate(dec_immediate), .ren_rs1(ren_rs1), .ren_rs2(ren_rs2),
		.ren_rd(ren_rd), .cur_rd(cur_inst.r_view.rd), .out_valid(out_valid),
		.out_pc(out_pc), .out_tag(out_tag), .alu_op(alu_op), .alu_src_imm(alu_src_imm),
		.mem_op(mem_op), .is_branch(is_branch), .reg_write(reg_write),
		.phys_rs1(phys_rs1), .phys_rs2(phys_rs2), .phys_rd(phys_rd), .arch_rd(arch_rd),
		.immediate(immediate)
	);

endmodule

//--- source/imm_generator.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sign-extended immediate per instruction format
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module imm_generator (
	input  decode_pkg::inst_word_t cur_inst,
	output logic [decode_pkg::inst_width-1:0] immediate
);

	logic [decode_pkg::inst_width-1:0] w;

	assign w = cur_inst;

	always_comb begin
		case (cur_inst.r_view.opcode)
			// I format
			decode_pkg::op_i, decode_pkg::op_load:
				immediate = {{20{w[31]}}, w[31:20]};
			// S format, split around rd
			decode_pkg::op_store:
				immediate = {{20{cur_inst.s_view.imm_hi[6]}}, cur_inst.s_view.imm_hi,
					cur_inst.s_view.imm_lo};
			// B format, even offsets
			decode_pkg::op_branch:
				immediate = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			decode_pkg::op_lui:
				immediate = {w[31:12], 12'b0};
			// J format
			decode_pkg::op_jal:
				immediate = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default:
				immediate = '0;
		endcase
	end

endmodule

//--- source/issue_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// holding register for a stalled instruction
// and the accept decision of the stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module issue_buffer #(
	parameter int addr_width = 32
) (
	input  logic clk,
	input  logic reset,
	input  logic inst_valid,
	input  decode_pkg::inst_word_t inst,
	input  logic [addr_width-1:0] pc,
	input  logic stall,
	input  logic flush,
	input  logic can_rename,
	input  logic rob_full,
	input  logic writes_rd,
	output logic inst_ready,
	output logic cur_valid,
	output decode_pkg::inst_word_t cur_inst,
	output logic [addr_width-1:0] cur_pc,
	output logic accept
);

	logic held_valid;
	decode_pkg::inst_word_t held_inst;
	logic [addr_width-1:0] held_pc;

	// held copy wins over the fetch input
	assign cur_valid = held_valid | inst_valid;
	assign cur_inst = held_valid ? held_inst : inst;
	assign cur_pc = held_valid ? held_pc : pc;
	assign inst_ready = ~held_valid;

	// a free register only matters for a writer
	assign accept = cur_valid & ~stall & ~flush & ~rob_full & (can_rename | ~writes_rd);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			held_valid <= 1'b0;
		end else begin
			held_valid <= cur_valid & ~accept & ~flush;
		end
	end

	always_ff @(posedge clk) begin
		if (cur_valid && !accept) begin
			held_inst <= cur_inst;
			held_pc <= cur_pc;
		end
	end

endmodule

//--- source/issue_register.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output register of the stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module issue_register #(
	parameter int addr_width = 32,
	parameter int phys_reg_width = 6,
	parameter int tag_width = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic accept,
	input  logic flush,
	input  logic cur_valid,
	input  logic [addr_width-1:0] cur_pc,
	input  logic [tag_width-1:0] next_tag,
	input  logic [3:0] dec_alu_op,
	input  logic dec_alu_src_imm,
	input  logic [1:0] dec_mem_op,
	input  logic dec_is_branch,
	input  logic dec_reg_write,
	input  logic [decode_pkg::inst_width-1:0] dec_immediate,
	input  logic [phys_reg_width-1:0] ren_rs1,
	input  logic [phys_reg_width-1:0] ren_rs2,
	input  logic [phys_reg_width-1:0] ren_rd,
	input  logic [decode_pkg::arch_reg_width-1:0] cur_rd,
	output logic out_valid,
	output logic [addr_width-1:0] out_pc,
	output logic [tag_width-1:0] out_tag,
	output logic [3:0] alu_op,
	output logic alu_src_imm,
	output logic [1:0] mem_op,
	output logic is_branch,
	output logic reg_write,
	output logic [phys_reg_width-1:0] phys_rs1,
	output logic [phys_reg_width-1:0] phys_rs2,
	output logic [phys_reg_width-1:0] phys_rd,
	output logic [decode_pkg::arch_reg_width-1:0] arch_rd,
	output logic [decode_pkg::inst_width-1:0] immediate
);

	// valid for one cycle per accept
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= accept & cur_valid & ~flush;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out_pc <= cur_pc;
			out_tag <= next_tag;
			alu_op <= dec_alu_op;
			alu_src_imm <= dec_alu_src_imm;
			mem_op <= dec_mem_op;
			is_branch <= dec_is_branch;
			reg_write <= dec_reg_write;
			immediate <= dec_immediate;
			phys_rs1 <= ren_rs1;
			phys_rs2 <= ren_rs2;
			phys_rd <= ren_rd;
			arch_rd <= cur_rd;
		end
	end

endmodule

//--- source/register_alias_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// architectural to physical map table
// and circular free list of physical registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module register_alias_table #(
	parameter int phys_reg_count = 64,
	parameter int phys_reg_width = $clog2(phys_reg_count),
	parameter int commit_width = 2
) (
	input  logic clk,
	input  logic reset,
	input  decode_pkg::inst_word_t cur_inst,
	input  logic reg_write,
	input  logic accept,
	input  logic [commit_width-1:0] commit_valid,
	input  logic [commit_width-1:0] commit_writes,
	input  logic [commit_width-1:0][phys_reg_width-1:0] commit_phys,
	output logic [phys_reg_width-1:0] phys_rs1,
	output logic [phys_reg_width-1:0] phys_rs2,
	output logic [phys_reg_width-1:0] phys_rd,
	output logic can_rename
);

	localparam int arch_regs = 2 ** decode_pkg::arch_reg_width;
	localparam int free_size = phys_reg_count - arch_regs;
	localparam int ptr_width = $clog2(free_size);
	localparam int cnt_width = $clog2(free_size + 1);

	logic [phys_reg_width-1:0] map_table [arch_regs];
	logic [phys_reg_width-1:0] free_list [free_size];
	logic [ptr_width-1:0] head;
	logic [ptr_width-1:0] tail;
	logic [cnt_width-1:0] free_cnt;
	logic [ptr_width-1:0] push_ptr [commit_width];
	logic [commit_width-1:0] push;
	logic [ptr_width-1:0] tail_next;
	logic [cnt_width-1:0] push_cnt;
	logic pop;

	function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] p);
		return (p == ptr_width'(free_size - 1)) ? '0 : p + 1'b1;
	endfunction

	// sources see the map before this rename
	assign phys_rs1 = map_table[cur_inst.r_view.rs1];
	assign phys_rs2 = map_table[cur_inst.r_view.rs2];
	assign phys_rd = free_list[head];
	assign can_rename = free_cnt != '0;
	assign pop = accept & reg_write;
	assign push = commit_valid & commit_writes;

	// pushing lanes take consecutive slots in lane order
	always_comb begin
		tail_next = tail;
		push_cnt = '0;
		for (int i = 0; i < commit_width; i++) begin
			push_ptr[i] = tail_next;
			if (push[i]) begin
				tail_next = next_ptr(tail_next);
				push_cnt = push_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < arch_regs; i++) begin
				map_table[i] <= phys_reg_width'(i);
			end
			for (int i = 0; i < free_size; i++) begin
				free_list[i] <= phys_reg_width'(arch_regs + i);
			end
			head <= '0;
			tail <= '0;
			free_cnt <= cnt_width'(free_size);
		end else begin
			if (pop) begin
				map_table[cur_inst.r_view.rd] <= free_list[head];
				head <= next_ptr(head);
			end
			for (int i = 0; i < commit_width; i++) begin
				if (push[i]) begin
					free_list[push_ptr[i]] <= commit_phys[i];
				end
			end
			tail <= tail_next;
			free_cnt <= free_cnt + push_cnt - cnt_width'(pop);
		end
	end

endmodule

//--- source/tag_allocator.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// in-order reorder buffer tag counter
// with in-flight count and full flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tag_allocator #(
	parameter int rob_size = 16,
	parameter int tag_width = $clog2(rob_size),
	parameter int commit_width = 2
) (
	input  logic clk,
	input  logic reset,
	input  logic accept,
	input  logic [commit_width-1:0] commit_valid,
	output logic [tag_width-1:0] next_tag,
	output logic rob_full
);

	logic [tag_width:0] in_flight;
	logic [tag_width:0] retired;

	// commits are in order so only their number matters
	always_comb begin
		retired = '0;
		for (int i = 0; i < commit_width; i++) begin
			retired = retired + commit_valid[i];
		end
	end

	assign rob_full = in_flight == (tag_width + 1)'(rob_size);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			next_tag <= '0;
			in_flight <= '0;
		end else begin
			if (accept) begin
				next_tag <= (next_tag == tag_width'(rob_size - 1)) ? '0 : next_tag + 1'b1;
			end
			in_flight <= in_flight + (tag_width + 1)'(accept) - retired;
		end
	end

endmodule

//--- testbench/decode_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model of decode, immediate, rename map,
// free list, tag count and the held instruction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

int m_map [32];
int m_free [$];
// old mapping of each in-flight instruction, -1 when it writes nothing
int m_pend [$];
int m_count;
int m_tag;
logic m_held_valid;
decode_pkg::inst_word_t m_held_inst;
logic [31:0] m_held_pc;

// outputs expected after the next rising edge
logic exp_valid;
logic [31:0] exp_pc;
logic [tag_w-1:0] exp_tag;
logic [3:0] exp_alu;
logic exp_src;
logic [1:0] exp_mem;
logic exp_br;
logic exp_rw;
logic [phys_w-1:0] exp_rs1;
logic [phys_w-1:0] exp_rs2;
logic [phys_w-1:0] exp_rd;
logic [4:0] exp_arch;
decode_pkg::inst_word_t exp_imm;
logic saw_rob_full;
logic saw_rename_block;
logic saw_flush_held;

task automatic expect_control(input decode_pkg::inst_word_t w, output logic [3:0] alu,
		output logic src, output logic [1:0] mem, output logic br, output logic rw);
	logic [6:0] op;
	logic wr;
	op = w.r_view.opcode;
	alu = decode_pkg::alu_add;
	src = op inside {decode_pkg::op_i, decode_pkg::op_load, decode_pkg::op_store,
		decode_pkg::op_lui, decode_pkg::op_jal};
	wr = op inside {decode_pkg::op_r, decode_pkg::op_i, decode_pkg::op_load,
		decode_pkg::op_lui, decode_pkg::op_jal};
	br = op inside {decode_pkg::op_branch, decode_pkg::op_jal};
	mem = (op == decode_pkg::op_load) ? decode_pkg::mem_load
		: (op == decode_pkg::op_store) ? decode_pkg::mem_store : decode_pkg::mem_none;
	if (op == decode_pkg::op_branch) alu = decode_pkg::alu_sub;
	// arithmetic ops, bit 30 picks sub (register form only) and sra
	if (op == decode_pkg::op_r || op == decode_pkg::op_i) begin
		case (w.r_view.funct3)
			3'd0: alu = (w[30] && op == decode_pkg::op_r) ? decode_pkg::alu_sub
				: decode_pkg::alu_add;
			3'd1: alu = decode_pkg::alu_sll;
			3'd2, 3'd3: alu = decode_pkg::alu_slt;
			3'd4: alu = decode_pkg::alu_xor;
			3'd5: alu = w[30] ? decode_pkg::alu_sra : decode_pkg::alu_srl;
			3'd6: alu = decode_pkg::alu_or;
			default: alu = decode_pkg::alu_and;
		endcase
	end
	rw = wr && (w.r_view.rd != 5'd0);
endtask

function automatic logic [31:0] expect_imm(input decode_pkg::inst_word_t w);
	case (w.r_view.opcode)
		decode_pkg::op_i, decode_pkg::op_load: return int'($signed(w[31:20]));
		decode_pkg::op_store: return int'($signed({w.s_view.imm_hi, w.s_view.imm_lo}));
		decode_pkg::op_branch: return int'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
		decode_pkg::op_lui: return {w[31:12], 12'h000};
		decode_pkg::op_jal: return int'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
		default: return 32'd0;
	endcase
endfunction

task automatic model_reset();
	for (int i = 0; i < 32; i++) m_map[i] = i;
	m_free.delete();
	for (int i = 32; i < phys_count; i++) m_free.push_back(i);
	m_pend.delete();
	m_count = 0;
	m_tag = 0;
	m_held_valid = 1'b0;
	exp_valid = 1'b0;
	saw_rob_full = 1'b0;
	saw_rename_block = 1'b0;
	saw_flush_held = 1'b0;
endtask

// one rising edge worth of state change, from the inputs now driven
task automatic model_step();
	logic cur_valid;
	decode_pkg::inst_word_t cur;
	logic [31:0] cur_pc;
	logic [3:0] alu;
	logic src;
	logic [1:0] mem;
	logic br;
	logic rw;
	logic acc;
	cur_valid = m_held_valid || inst_valid;
	cur = m_held_valid ? m_held_inst : inst;
	cur_pc = m_held_valid ? m_held_pc : pc;
	expect_control(cur, alu, src, mem, br, rw);
	acc = cur_valid && !stall && !flush && m_count < rob_size && (m_free.size() > 0 || !rw);
	if (m_count == rob_size) saw_rob_full = 1'b1;
	if (cur_valid && rw && m_free.size() == 0) saw_rename_block = 1'b1;
	if (flush && m_held_valid) saw_flush_held = 1'b1;
	exp_valid = acc;
	if (acc) begin
		exp_pc = cur_pc;
		exp_tag = tag_w'(m_tag);
		{exp_alu, exp_src, exp_mem, exp_br, exp_rw} = {alu, src, mem, br, rw};
		exp_imm = expect_imm(cur);
		exp_rs1 = phys_w'(m_map[cur.r_view.rs1]);
		exp_rs2 = phys_w'(m_map[cur.r_view.rs2]);
		exp_arch = cur.r_view.rd;
		if (rw) begin
			exp_rd = phys_w'(m_free.pop_front());
			m_pend.push_back(m_map[cur.r_view.rd]);
			m_map[cur.r_view.rd] = exp_rd;
		end else begin
			m_pend.push_back(-1);
		end
		m_tag = (m_tag + 1) % rob_size;
		m_count++;
	end
	if (cur_valid && !acc) begin
		m_held_inst = cur;
		m_held_pc = cur_pc;
	end
	m_held_valid = cur_valid && !acc && !flush;
	for (int i = 0; i < commit_width; i++) begin
		if (commit_valid[i]) m_count--;
		if (commit_valid[i] && commit_writes[i]) m_free.push_back(int'(commit_phys[i]));
	end
endtask

//--- testbench/decode_stage_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the decode and rename stage
// LCG stimulus, model compare, timeout and report
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_stage_tb;

	localparam int phys_count = 64;
	localparam int rob_size = 16;
	localparam int commit_width = 2;
	localparam int phys_w = $clog2(phys_count);
	localparam int tag_w = $clog2(rob_size);
	// phases: no commits, tag-only commits, full traffic, drain
	localparam int end_no_commit = 40;
	localparam int end_tag_only = 300;
	localparam int end_traffic = 2300;
	localparam int run_cycles = 2320;
	localparam int cycle_limit = 16 + run_cycles + 200;

	logic clk;
	logic reset;
	logic inst_valid;
	decode_pkg::inst_word_t inst;
	logic [31:0] pc;
	logic stall;
	logic flush;
	logic [commit_width-1:0] commit_valid;
	logic [commit_width-1:0] commit_writes;
	logic [commit_width-1:0][phys_w-1:0] commit_phys;
	logic inst_ready;
	logic out_valid;
	logic [31:0] out_pc;
	logic [tag_w-1:0] out_tag;
	logic rob_full;
	logic [3:0] alu_op;
	logic alu_src_imm;
	logic [1:0] mem_op;
	logic is_branch;
	logic reg_write;
	logic [phys_w-1:0] phys_rs1;
	logic [phys_w-1:0] phys_rs2;
	logic [phys_w-1:0] phys_rd;
	logic [4:0] arch_rd;
	logic [31:0] immediate;

	logic [31:0] lcg_state;
	logic [31:0] next_pc;
	int to_free [$];
	int mismatches;
	int other_errors;
	int cycle_count;

	decode_stage #(
		.phys_reg_count(phys_count), .rob_size(rob_size), .commit_width(commit_width),
		.addr_width(32)
	) dut0 (
		.clk(clk), .reset(reset), .inst_valid(inst_valid), .inst(inst), .pc(pc),
		.stall(stall), .flush(flush), .commit_valid(commit_valid),
		.commit_writes(commit_writes), .commit_phys(commit_phys), .inst_ready(inst_ready),
		.out_valid(out_valid), .out_pc(out_pc), .out_tag(out_tag), .rob_full(rob_full),
		.alu_op(alu_op), .alu_src_imm(alu_src_imm), .mem_op(mem_op), .is_branch(is_branch),
		.reg_write(reg_write), .phys_rs1(phys_rs1), .phys_rs2(phys_rs2), .phys_rd(phys_rd),
		.arch_rd(arch_rd), .immediate(immediate)
	);

	`include "decode_model.svh"

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// upper bits only, the low ones of an LCG repeat quickly
	function automatic int unsigned rand_below(input int unsigned n);
		return (lcg_next() >> 16) % n;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got, exp);
		mismatches++;
		$display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
	endtask

	task automatic check_flag(input string name, input logic got, exp);
		if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
	endtask
	task automatic check_alu_op(input string name, input logic [3:0] got, exp);
		if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
	endtask
	task automatic check_mem_op(input string name, input logic [1:0] got, exp);
		if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
	endtask
	task automatic check_word(input string name, input decode_pkg::inst_word_t got, exp);
		if (got !== exp) report_mismatch(name, got, exp);
	endtask
	task automatic check_addr(input string name, input logic [31:0] got, exp);
		if (got !== exp) report_mismatch(name, got, exp);
	endtask
	task automatic check_phys(input string name, input logic [phys_w-1:0] got, exp);
		if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
	endtask
	task automatic check_arch(input string name, input logic [4:0] got, exp);
		if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
	endtask
	task automatic check_tag(input string name, input logic [tag_w-1:0] got, exp);
		if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic compare_outputs();
		check_flag("out_valid", out_valid, exp_valid);
		check_flag("inst_ready", inst_ready, !m_held_valid);
		check_flag("rob_full", rob_full, m_count == rob_size);
		if (exp_valid) begin
			check_addr("out_pc", out_pc, exp_pc);
			check_tag("out_tag", out_tag, exp_tag);
			check_alu_op("alu_op", alu_op, exp_alu);
			check_flag("alu_src_imm", alu_src_imm, exp_src);
			check_mem_op("mem_op", mem_op, exp_mem);
			check_flag("is_branch", is_branch, exp_br);
			check_flag("reg_write", reg_write, exp_rw);
			check_word("immediate", immediate, exp_imm);
			check_phys("phys_rs1", phys_rs1, exp_rs1);
			check_phys("phys_rs2", phys_rs2, exp_rs2);
			if (exp_rw) check_phys("phys_rd", phys_rd, exp_rd);
			check_arch("arch_rd", arch_rd, exp_arch);
		end
	endtask

	function automatic decode_pkg::inst_word_t make_inst();
		decode_pkg::inst_word_t w;
		int unsigned kind;
		w = lcg_next();
		kind = rand_below(8);
		case (kind)
			0: w.r_view.opcode = decode_pkg::op_r;
			1: w.r_view.opcode = decode_pkg::op_i;
			2: w.r_view.opcode = decode_pkg::op_load;
			3: w.r_view.opcode = decode_pkg::op_store;
			4: w.r_view.opcode = decode_pkg::op_branch;
			5: w.r_view.opcode = decode_pkg::op_lui;
			6: w.r_view.opcode = decode_pkg::op_jal;
			default: w.r_view.opcode = decode_pkg::op_nop;
		endcase
		// funct7 of register ops is 0x00 or 0x20
		if (kind == 0) w.r_view.funct7 = {1'b0, w.r_view.funct7[5], 5'b0};
		if (rand_below(8) == 0) w.r_view.rd = 5'd0;
		return w;
	endfunction

	// oldest in-flight instructions retire first, tag-only phase keeps two in flight
	task automatic choose_commits(input int phase);
		int old;
		commit_valid = '0;
		commit_writes = '0;
		commit_phys = '0;
		for (int i = 0; i < commit_width; i++) begin
			if (phase != 0 && m_pend.size() > ((phase == 1) ? 2 : 0) && rand_below(2) == 0) begin
				old = m_pend.pop_front();
				if (old >= 0) to_free.push_back(old);
				commit_valid[i] = 1'b1;
				if (phase != 1 && to_free.size() > 0) begin
					commit_writes[i] = 1'b1;
					commit_phys[i] = phys_w'(to_free.pop_front());
				end
			end
		end
	endtask

	task automatic drive_inputs(input int cyc);
		int phase;
		phase = (cyc < end_no_commit) ? 0 : (cyc < end_tag_only) ? 1
			: (cyc < end_traffic) ? 2 : 3;
		stall = (phase == 1 || phase == 2) && rand_below(4) == 0;
		flush = phase == 2 && rand_below(16) == 0;
		// fetch only offers while nothing is held
		if (!m_held_valid && phase != 3 && (phase < 2 || rand_below(8) != 0)) begin
			inst_valid = 1'b1;
			inst = make_inst();
			pc = next_pc;
			next_pc = next_pc + 32'd4;
		end else begin
			inst_valid = 1'b0;
		end
		choose_commits(phase);
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		pc = '0;
		stall = 1'b0;
		flush = 1'b0;
		commit_valid = '0;
		commit_writes = '0;
		commit_phys = '0;
		lcg_state = 32'd4;
		next_pc = 32'h1000;
		mismatches = 0;
		other_errors = 0;
		cycle_count = 0;
		model_reset();
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int cyc = 0; cyc < run_cycles; cyc++) begin
			compare_outputs();
			drive_inputs(cyc);
			model_step();
			@(negedge clk);
		end
		if (!saw_rob_full) begin
			other_errors++;
			$display("rob_full was never reached during the run");
		end
		if (!saw_rename_block) begin
			other_errors++;
			$display("the free list never ran empty under a waiting writer");
		end
		if (!saw_flush_held) begin
			other_errors++;
			$display("no flush ever hit a held instruction");
		end
		$display("errors: %0d mismatches, %0d other", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
